/* logic/baud_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
    input  logic                   clk,
    input  logic                   reset_n,
    input  uart_rx_pkg::baud_div_t baud_div_i,
    output logic                   tick_o
);

    uart_rx_pkg::baud_div_t cnt_q;
    logic                   reload;

    // zero only right after reset, so the first reload happens at once
    assign reload = (cnt_q <= uart_rx_pkg::baud_div_t'(1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q <= '0;
        end else if (reload) begin
            cnt_q <= baud_div_i;  // new divisor picked up here
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign tick_o = (cnt_q == uart_rx_pkg::baud_div_t'(1));

endmodule

`default_nettype wire

/* logic/receiver_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defines.svh"

module receiver_fifo (
    input  logic                    clk,
    input  logic                    reset_n,
    input  uart_rx_pkg::uart_data_t fifo_rx_i,
    input  logic                    fifo_rx_push_i,
    input  logic                    fifo_rx_pop_i,
    input  logic                    fifo_rx_reset_i,
    output uart_rx_pkg::uart_data_t fifo_rx_o,
    output logic                    fifo_rx_empty_o,
    output logic                    fifo_rx_full_o
);

    localparam int unsigned CNT_W = `UART_FIFO_PTR_W + 1;

    uart_rx_pkg::uart_data_t mem [`UART_FIFO_DEPTH];
    uart_rx_pkg::fifo_ptr_t  wr_ptr_q;
    uart_rx_pkg::fifo_ptr_t  rd_ptr_q;
    logic [CNT_W-1:0]        count_q;
    logic                    do_push;
    logic                    do_pop;

    assign fifo_rx_empty_o = (count_q == '0);
    assign fifo_rx_full_o  = (count_q == CNT_W'(`UART_FIFO_DEPTH));

    assign do_push = fifo_rx_push_i && !fifo_rx_full_o;   // dropped when full
    assign do_pop  = fifo_rx_pop_i && !fifo_rx_empty_o;

    always_ff @(posedge clk) begin
        if (do_push && !fifo_rx_reset_i) begin
            mem[wr_ptr_q] <= fifo_rx_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (fifo_rx_reset_i) begin
            wr_ptr_q <= '0;  // flush in one clock
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // show-ahead head, incoming word passes straight through when empty
    assign fifo_rx_o = fifo_rx_empty_o ? fifo_rx_i : mem[rd_ptr_q];

endmodule

`default_nettype wire

/* logic/rx_shift_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_shift_reg (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    shift_i,
    input  logic                    clear_i,
    input  logic                    bit_i,
    input  uart_rx_pkg::data_bits_t data_bit_num_i,
    output uart_rx_pkg::uart_data_t data_o,
    output logic                    parity_o
);

    uart_rx_pkg::uart_data_t shift_q;
    logic                    parity_q;
    logic [1:0]              align;

    // lsb arrives first and ends up lowest once all bits are in
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift_q  <= '0;
            parity_q <= 1'b0;
        end else if (clear_i) begin
            shift_q  <= '0;
            parity_q <= 1'b0;
        end else if (shift_i) begin
            shift_q  <= {bit_i, shift_q[7:1]};
            parity_q <= parity_q ^ bit_i;  // running xor of data bits
        end
    end

    // N bits sit in the top N positions, move them down by 8 - N
    assign align  = 2'd3 - data_bit_num_i;
    assign data_o = shift_q >> align;

    assign parity_o = parity_q;

endmodule

`default_nettype wire

/* logic/uart_rx_defines.svh */
`ifndef UART_RX_DEFINES_SVH
`define UART_RX_DEFINES_SVH

// receiver oversampling, ticks per serial bit
`define UART_OVERSAMPLE 16

// tick index of the middle of a bit
`define UART_SAMPLE_POINT 7

// receive FIFO geometry, depth must stay a power of two
`define UART_FIFO_DEPTH 8
`define UART_FIFO_PTR_W 3

`endif

/* logic/uart_rx_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defines.svh"

module uart_rx_fsm (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    rx_en_i,
    input  logic                    tick_i,
    input  logic                    rx_i,
    input  logic                    parity_en_i,
    input  logic                    parity_type_i,
    input  logic                    stop_bit_num_i,
    input  uart_rx_pkg::data_bits_t data_bit_num_i,
    input  logic                    parity_i,
    output logic                    shift_o,
    output logic                    clear_o,
    output logic                    bit_o,
    output logic                    data_valid_o,
    output logic                    parity_err_o,
    output logic                    stop_bit_err_o
);

    localparam logic [3:0] SAMPLE_TICK = 4'(`UART_SAMPLE_POINT);
    localparam logic [3:0] LAST_TICK   = 4'(`UART_OVERSAMPLE - 1);

    uart_rx_pkg::rx_state_t state_q;
    logic [3:0]             os_cnt_q;   // tick index inside the current bit
    uart_rx_pkg::bit_cnt_t  bit_cnt_q;
    uart_rx_pkg::bit_cnt_t  n_bits;
    logic                   par_err_q;  // held until the frame completes
    logic                   stop_err_q;
    logic                   start_seen;
    logic                   mid_bit;
    logic                   end_bit;

    assign n_bits     = 4'd5 + {2'b00, data_bit_num_i};
    assign start_seen = rx_en_i && (state_q == uart_rx_pkg::IDLE) && tick_i && !rx_i;
    assign mid_bit    = tick_i && (os_cnt_q == SAMPLE_TICK);
    assign end_bit    = tick_i && (os_cnt_q == LAST_TICK);

    // shift register control
    assign clear_o = start_seen;
    assign shift_o = rx_en_i && (state_q == uart_rx_pkg::DATA) && mid_bit;
    assign bit_o   = rx_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q        <= uart_rx_pkg::IDLE;
            os_cnt_q       <= '0;
            bit_cnt_q      <= '0;
            par_err_q      <= 1'b0;
            stop_err_q     <= 1'b0;
            data_valid_o   <= 1'b0;
            parity_err_o   <= 1'b0;
            stop_bit_err_o <= 1'b0;
        end else begin
            data_valid_o <= 1'b0;
            if (tick_i) begin
                os_cnt_q <= os_cnt_q + 4'd1;  // wraps at the end of each bit
            end
            if (!rx_en_i) begin
                state_q <= uart_rx_pkg::IDLE;  // abort whatever is in flight
            end else begin
                case (state_q)
                    uart_rx_pkg::IDLE: begin
                        if (start_seen) begin
                            state_q    <= uart_rx_pkg::START;
                            os_cnt_q   <= 4'd1;  // this tick was tick 0
                            bit_cnt_q  <= '0;
                            par_err_q  <= 1'b0;
                            stop_err_q <= 1'b0;
                        end
                    end
                    uart_rx_pkg::START: begin
                        if (mid_bit && rx_i) begin
                            state_q <= uart_rx_pkg::IDLE;  // glitch, not a start bit
                        end else if (end_bit) begin
                            state_q <= uart_rx_pkg::DATA;
                        end
                    end
                    uart_rx_pkg::DATA: begin
                        if (mid_bit) begin
                            bit_cnt_q <= bit_cnt_q + 4'd1;
                        end
                        if (end_bit && (bit_cnt_q == n_bits)) begin
                            state_q   <= parity_en_i ? uart_rx_pkg::PARITY : uart_rx_pkg::STOP;
                            bit_cnt_q <= '0;
                        end
                    end
                    uart_rx_pkg::PARITY: begin
                        // even parity expects the data xor, odd its inverse
                        if (mid_bit) begin
                            par_err_q <= (rx_i != (parity_i ^ parity_type_i));
                        end
                        if (end_bit) begin
                            state_q <= uart_rx_pkg::STOP;
                        end
                    end
                    uart_rx_pkg::STOP: begin
                        if (mid_bit) begin
                            if (stop_bit_num_i && (bit_cnt_q == '0)) begin
                                stop_err_q <= ~rx_i;  // first of two stop bits
                                bit_cnt_q  <= 4'd1;
                            end else begin
                                state_q        <= uart_rx_pkg::IDLE;
                                data_valid_o   <= 1'b1;
                                parity_err_o   <= par_err_q;
                                stop_bit_err_o <= stop_err_q | ~rx_i;
                            end
                        end
                    end
                    default: state_q <= uart_rx_pkg::IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/uart_rx_pkg.sv */
`default_nettype none

`include "uart_rx_defines.svh"

package uart_rx_pkg;

    typedef logic [7:0]  uart_data_t;  // received character, right aligned
    typedef logic [15:0] baud_div_t;   // clocks per oversampling tick

    // 0 -> 5 data bits ... 3 -> 8 data bits
    typedef logic [1:0]  data_bits_t;

    typedef logic [3:0]  bit_cnt_t;    // bits received in the current field

    typedef logic [`UART_FIFO_PTR_W-1:0] fifo_ptr_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } rx_state_t;

endpackage

`default_nettype wire

/* logic/uart_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    rx_en_i,
    input  uart_rx_pkg::baud_div_t  baud_div_i,
    input  logic                    parity_type_i,
    input  logic                    parity_en_i,
    input  logic                    tx_i,           // serial line, idle high
    input  logic                    stop_bit_num_i,
    input  uart_rx_pkg::data_bits_t data_bit_num_i,
    input  logic                    fifo_en_i,
    input  logic                    fifo_rx_pop_i,
    input  logic                    fifo_rx_reset_i,
    output uart_rx_pkg::uart_data_t data_o,
    output logic                    data_o_valid,
    output logic                    parity_err_o,
    output logic                    stop_bit_err_o,
    output logic                    fifo_rx_empty_o,
    output logic                    fifo_rx_overrun
);

    logic                    tick;
    logic                    shift;
    logic                    clear;
    logic                    rx_bit;
    uart_rx_pkg::uart_data_t rx_data;
    logic                    rx_parity;
    logic                    rx_valid;
    logic                    fifo_push;
    uart_rx_pkg::uart_data_t fifo_out;
    logic                    fifo_full;
    logic                    pop_d;
    logic                    pop_fall;

    baud_tick_gen tick_gen0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .baud_div_i (baud_div_i),
        .tick_o     (tick)
    );

    uart_rx_fsm fsm0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .rx_en_i        (rx_en_i),
        .tick_i         (tick),
        .rx_i           (tx_i),
        .parity_en_i    (parity_en_i),
        .parity_type_i  (parity_type_i),
        .stop_bit_num_i (stop_bit_num_i),
        .data_bit_num_i (data_bit_num_i),
        .parity_i       (rx_parity),
        .shift_o        (shift),
        .clear_o        (clear),
        .bit_o          (rx_bit),
        .data_valid_o   (rx_valid),
        .parity_err_o   (parity_err_o),
        .stop_bit_err_o (stop_bit_err_o)
    );

    rx_shift_reg shift_reg0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .shift_i        (shift),
        .clear_i        (clear),
        .bit_i          (rx_bit),
        .data_bit_num_i (data_bit_num_i),
        .data_o         (rx_data),
        .parity_o       (rx_parity)
    );

    assign fifo_push = fifo_en_i & rx_valid;

    receiver_fifo fifo0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .fifo_rx_i       (rx_data),
        .fifo_rx_push_i  (fifo_push),
        .fifo_rx_pop_i   (fifo_rx_pop_i),
        .fifo_rx_reset_i (fifo_rx_reset_i),
        .fifo_rx_o       (fifo_out),
        .fifo_rx_empty_o (fifo_rx_empty_o),
        .fifo_rx_full_o  (fifo_full)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pop_d <= 1'b0;
        end else begin
            pop_d <= fifo_rx_pop_i;
        end
    end

    assign pop_fall        = pop_d & ~fifo_rx_pop_i;  // host finished a pop
    assign fifo_rx_overrun = fifo_push & fifo_full;   // word is lost

    always_comb begin
        if (fifo_en_i) begin
            data_o       = fifo_out;
            data_o_valid = (fifo_rx_empty_o & rx_valid) | (~fifo_rx_empty_o & pop_fall);
        end else begin
            data_o       = rx_data;
            data_o_valid = rx_valid;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module uart_rx_tb \
    -f tb.f -o uart_rx_sim &&
./obj_dir/uart_rx_sim || exit 1

/* tb.f */
+incdir+logic
logic/uart_rx_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx_fsm.sv
logic/rx_shift_reg.sv
logic/receiver_fifo.sv
logic/uart_rx_top.sv
test/uart_rx_properties.sv
test/uart_rx_tb.sv

/* test/uart_rx_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_properties (
    input logic clk,
    input logic reset_n,
    input logic fifo_en_i,
    input logic data_o_valid,
    input logic fifo_rx_empty_o,
    input logic fifo_rx_overrun
);

    // a dropped word means the FIFO already held data, this clock and the one before
    overrun_needs_data: assert property (@(posedge clk) disable iff (!reset_n)
        fifo_rx_overrun |-> (!fifo_rx_empty_o && !$past(fifo_rx_empty_o)))
        else $error("fifo_rx_overrun raised while the FIFO is or just was empty");

    valid_single_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        (!fifo_en_i && data_o_valid) |=> !data_o_valid)
        else $error("data_o_valid longer than one clock with the FIFO off");

    quiet_in_reset: assert property (@(posedge clk)
        !reset_n |-> (!data_o_valid && !fifo_rx_overrun))
        else $error("valid or overrun seen during reset");

endmodule

`default_nettype wire

/* test/uart_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defines.svh"

module uart_rx_tb;

    localparam int BIT_CLKS = 4 * `UART_OVERSAMPLE;  // baud_div_i stays at 4

    logic clk, reset_n, rx_en_i, tx_i;
    logic parity_type_i, parity_en_i, stop_bit_num_i;
    logic fifo_en_i, fifo_rx_pop_i, fifo_rx_reset_i;
    uart_rx_pkg::baud_div_t  baud_div_i;
    uart_rx_pkg::data_bits_t data_bit_num_i;
    uart_rx_pkg::uart_data_t data_o;
    logic data_o_valid, parity_err_o, stop_bit_err_o, fifo_rx_empty_o, fifo_rx_overrun;

    logic [15:0]             lfsr;
    logic [9:0]              exp_q[$];      // {parity err, stop err, word}
    uart_rx_pkg::uart_data_t fifo_model[$];
    int                      overruns_seen;
    int                      overruns_expected;

    uart_rx_top dut0 (.*);

    bind uart_rx_top uart_rx_properties props0 (
        .clk(clk), .reset_n(reset_n), .fifo_en_i(fifo_en_i), .data_o_valid(data_o_valid),
        .fifo_rx_empty_o(fifo_rx_empty_o), .fifo_rx_overrun(fifo_rx_overrun));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[6:0], fb};
        end
        return r;
    endfunction

    task automatic fail_value(input string name, input logic [7:0] got, input logic [7:0] want);
        $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
        $display("TESTBENCH FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", what);
    endtask

    // outputs are looked at just before the rising edge, control returns at the falling edge
    task automatic step();
        logic [9:0] want;
        @(posedge clk);
        if (fifo_rx_overrun)
            overruns_seen++;
        if (data_o_valid) begin
            assert (exp_q.size() > 0) else fail_plain("data_o_valid pulsed with no word expected");
            want = exp_q.pop_front();
            assert (data_o == want[7:0]) else fail_value("data_o", data_o, want[7:0]);
            if (!fifo_en_i) begin  // error levels belong to the receiver path
                assert (parity_err_o == want[9])
                    else fail_value("parity_err_o", 8'(parity_err_o), 8'(want[9]));
                assert (stop_bit_err_o == want[8])
                    else fail_value("stop_bit_err_o", 8'(stop_bit_err_o), 8'(want[8]));
            end
        end
        @(negedge clk);
    endtask

    task automatic drive_line(input logic b, input int clks);
        tx_i = b;
        repeat (clks) step();
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            if (waited == 4 * BIT_CLKS)
                fail_plain("timed out waiting for data_o_valid");
            step();
            waited++;
        end
    endtask

    // one frame with the current configuration, lsb first
    task automatic send_frame(input logic [7:0] ch, input logic bad_par, input logic bad_stop,
                              input int abort_bit);
        int         nbits;
        logic [7:0] word;
        logic       par;
        nbits = 5 + int'(data_bit_num_i);
        word  = ch & 8'((1 << nbits) - 1);
        par   = (^word) ^ parity_type_i ^ bad_par;  // even: total count of ones is even
        if (abort_bit < 0) begin
            if (!fifo_en_i) begin
                exp_q.push_back({parity_en_i & bad_par, bad_stop, word});
            end else begin
                if (fifo_model.size() == 0)
                    exp_q.push_back({2'b00, word});  // passes straight through when empty
                if (fifo_model.size() < `UART_FIFO_DEPTH)
                    fifo_model.push_back(word);
                else
                    overruns_expected++;
            end
        end
        drive_line(1'b0, BIT_CLKS);
        for (int i = 0; i < nbits; i++) begin
            if (i == abort_bit)
                rx_en_i = 1'b0;
            drive_line(word[i], BIT_CLKS);
        end
        if (parity_en_i)
            drive_line(par, BIT_CLKS);
        if (stop_bit_num_i)
            drive_line(1'b1, BIT_CLKS);
        if (bad_stop) begin
            // low past the sample point, high again before a new start bit is confirmed
            drive_line(1'b0, BIT_CLKS * 5 / 8);
            drive_line(1'b1, BIT_CLKS * 3 / 8);
        end else begin
            drive_line(1'b1, BIT_CLKS);
        end
        drive_line(1'b1, 2 * BIT_CLKS);  // idle gap
    endtask

    task automatic random_config();
        data_bit_num_i = uart_rx_pkg::data_bits_t'(rand_bits(2));
        parity_en_i    = 1'(rand_bits(1));
        parity_type_i  = 1'(rand_bits(1));
        stop_bit_num_i = 1'(rand_bits(1));
    endtask

    task automatic random_frame(input logic inject);
        logic [7:0] ch;
        logic       bad_par;
        logic       bad_stop;
        random_config();
        ch       = rand_bits(8);
        bad_par  = (rand_bits(2) == 8'd0) && inject && parity_en_i;  // about one in four
        bad_stop = (rand_bits(2) == 8'd0) && inject;
        send_frame(ch, bad_par, bad_stop, -1);
    endtask

    task automatic pop_word();
        fifo_rx_pop_i = 1'b1;
        step();
        fifo_rx_pop_i = 1'b0;
        if (fifo_model.size() > 0) begin
            fifo_model.delete(0);
            if (fifo_model.size() > 0)
                exp_q.push_back({2'b00, fifo_model[0]});  // next head after pop falls
        end
        step();
        wait_drained();
        assert (fifo_rx_empty_o == (fifo_model.size() == 0))
            else fail_value("fifo_rx_empty_o", 8'(fifo_rx_empty_o), 8'(fifo_model.size() == 0));
    endtask

    task automatic flush_fifo();
        fifo_rx_reset_i = 1'b1;
        step();
        fifo_rx_reset_i = 1'b0;
        fifo_model.delete();
        step();
        assert (fifo_rx_empty_o) else fail_plain("fifo_rx_empty_o stayed low after the flush");
    endtask

    initial begin
        int n;
        reset_n           = 1'b0;
        rx_en_i           = 1'b1;
        tx_i              = 1'b1;
        baud_div_i        = 16'd4;
        parity_type_i     = 1'b0;
        parity_en_i       = 1'b0;
        stop_bit_num_i    = 1'b0;
        data_bit_num_i    = 2'd3;
        fifo_en_i         = 1'b0;
        fifo_rx_pop_i     = 1'b0;
        fifo_rx_reset_i   = 1'b0;
        lfsr              = 16'd35405;
        overruns_seen     = 0;
        overruns_expected = 0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        repeat (BIT_CLKS) step();

        for (n = 0; n < 12; n++) begin  // FIFO off, random errors
            random_frame(1'b1);
            wait_drained();
        end
        parity_en_i = 1'b1;
        send_frame(rand_bits(8), 1'b1, 1'b0, -1);
        send_frame(rand_bits(8), 1'b0, 1'b0, -1);  // clean frame clears both flags
        send_frame(rand_bits(8), 1'b0, 1'b1, -1);
        send_frame(rand_bits(8), 1'b0, 1'b0, -1);
        wait_drained();

        fifo_en_i = 1'b1;
        for (n = 0; n < 4; n++)
            random_frame(1'b0);
        wait_drained();
        for (n = 0; n < 4; n++)
            pop_word();

        // one frame more than the FIFO holds
        for (n = 0; n <= `UART_FIFO_DEPTH; n++)
            random_frame(1'b0);
        wait_drained();
        assert (overruns_seen == overruns_expected)
            else fail_plain("fifo_rx_overrun did not pulse once on the extra frame");
        for (n = 0; n < `UART_FIFO_DEPTH; n++)
            pop_word();

        for (n = 0; n < 3; n++)
            random_frame(1'b0);
        wait_drained();
        flush_fifo();
        random_frame(1'b0);
        wait_drained();
        flush_fifo();

        fifo_en_i = 1'b0;
        random_config();
        send_frame(rand_bits(8), 1'b0, 1'b0, 2);  // receiver switched off mid frame
        rx_en_i = 1'b1;
        random_frame(1'b0);
        wait_drained();

        if (exp_q.size() == 0 && overruns_seen == overruns_expected) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "words or overrun pulses left unaccounted");
        end
    end

endmodule

`default_nettype wire
